// ==== lsu_pkg.sv ====
// Shared definitions for the load/store unit
// Data width, data RAM depth, access size and APB state encodings

package lsu_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths and depths
  //////////////////////////////////////////////////////////////////////

  // Data and address width, RV32 only
  localparam int XLEN = 32;

  // Data RAM depth in words
  localparam int RAM_WORDS = 256;

  // Word index width for the data RAM
  localparam int RAM_AW = $clog2(RAM_WORDS);

  //////////////////////////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////////////////////////

  // Access size as issued by the CPU
  // Codes above DWORD are unused and treated as misaligned
  typedef enum logic [2:0] {
    BYTE  = 3'd0,
    HWORD = 3'd1,
    WORD  = 3'd2,
    DWORD = 3'd3
  } mem_size_t;

  // APB master phases
  typedef enum logic [1:0] {
    IDLE   = 2'd0,
    SETUP  = 2'd1,
    ACCESS = 2'd2
  } apb_state_t;

endpackage

// ==== lsu_misaligned.sv ====
// Alignment check for CPU data accesses
// Combinational check result plus the registered flag back to the CPU

`timescale 1ns/1ps

module lsu_misaligned import lsu_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  logic            req,
  input  logic [XLEN-1:0] adr,
  input  mem_size_t       size,
  output logic            mem_misaligned,
  output logic            is_misaligned
);

  // Size versus low address bits
  always_comb begin
    case (size)
      // Byte is always aligned
      BYTE:    is_misaligned = 1'b0;
      // Halfword needs an even address
      HWORD:   is_misaligned = adr[0];
      // Word needs a multiple of four
      WORD:    is_misaligned = |adr[1:0];
      // DWORD has no place on RV32, same for unused codes
      default: is_misaligned = 1'b1;
    endcase
  end

  // Flag follows the request by one cycle
  // Cleared on any cycle without a request
  always_ff @(posedge clk) begin
    if (rst) begin
      mem_misaligned <= 1'b0;
    end else if (req) begin
      mem_misaligned <= is_misaligned;
    end else begin
      mem_misaligned <= 1'b0;
    end
  end

endmodule

// ==== lsu_data_align.sv ====
// Byte-lane steering between the CPU and the 32-bit data bus
// Store side replicates data and builds strobes
// Load side shifts down and extends

`timescale 1ns/1ps

module lsu_data_align import lsu_pkg::*; (
  // Store direction
  input  mem_size_t       size,
  input  logic [1:0]      byte_ofs,
  input  logic [XLEN-1:0] wdata,
  output logic [XLEN-1:0] lane_wdata,
  output logic [3:0]      lane_strb,

  // Load direction
  input  mem_size_t       rd_size,
  input  logic [1:0]      rd_ofs,
  input  logic            rd_unsigned,
  input  logic [XLEN-1:0] raw_rdata,
  output logic [XLEN-1:0] rdata
);

  // Read word with the addressed byte moved to lane 0
  logic [XLEN-1:0] rd_shifted;

  //////////////////////////////////////////////////////////////////////
  // Store lanes
  //////////////////////////////////////////////////////////////////////

  // Data goes to every lane, strobes pick the real target
  always_comb begin
    case (size)
      BYTE: begin
        lane_wdata = {4{wdata[7:0]}};
        lane_strb  = 4'b0001 << byte_ofs;
      end
      HWORD: begin
        lane_wdata = {2{wdata[15:0]}};
        // Offset bit 0 is clear for any aligned halfword
        lane_strb  = 4'b0011 << byte_ofs;
      end
      WORD: begin
        lane_wdata = wdata;
        lane_strb  = 4'b1111;
      end
      default: begin
        // Misaligned sizes never reach the bus
        lane_wdata = wdata;
        lane_strb  = 4'b0000;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Load extraction
  //////////////////////////////////////////////////////////////////////

  // Shift by offset times eight bits
  assign rd_shifted = raw_rdata >> {rd_ofs, 3'b000};

  always_comb begin
    case (rd_size)
      BYTE: begin
        if (rd_unsigned) begin
          rdata = {{(XLEN-8){1'b0}}, rd_shifted[7:0]};
        end else begin
          rdata = {{(XLEN-8){rd_shifted[7]}}, rd_shifted[7:0]};
        end
      end
      HWORD: begin
        if (rd_unsigned) begin
          rdata = {{(XLEN-16){1'b0}}, rd_shifted[15:0]};
        end else begin
          rdata = {{(XLEN-16){rd_shifted[15]}}, rd_shifted[15:0]};
        end
      end
      // Full word as read
      default: rdata = raw_rdata;
    endcase
  end

endmodule

// ==== lsu_apb_master.sv ====
// APB master for single CPU data accesses
// Captures one aligned request, runs SETUP and ACCESS, returns ack
// Read word and load attributes go back to the aligner

`timescale 1ns/1ps

module lsu_apb_master import lsu_pkg::*; (
  input  logic            clk,
  input  logic            rst,

  // Request side
  input  logic            req,
  input  logic            we,
  input  logic            is_misaligned,
  input  logic [XLEN-1:0] adr,
  input  mem_size_t       size,
  input  logic            load_unsigned,
  input  logic [XLEN-1:0] lane_wdata,
  input  logic [3:0]      lane_strb,

  // Completion side
  output logic            busy,
  output logic            ack,
  output logic            access_err,
  output mem_size_t       rd_size,
  output logic [1:0]      rd_ofs,
  output logic            rd_unsigned,
  output logic [XLEN-1:0] raw_rdata,

  // APB
  output logic [XLEN-1:0] paddr,
  output logic            psel,
  output logic            penable,
  output logic            pwrite,
  output logic [XLEN-1:0] pwdata,
  output logic [3:0]      pstrb,
  input  logic [XLEN-1:0] prdata,
  input  logic            pready,
  input  logic            pslverr
);

  apb_state_t state;
  logic       start;

  // Accept only in IDLE and not in the ack cycle
  assign start = req & ~is_misaligned & (state == IDLE) & ~ack;

  // Busy from first bus cycle through the ack cycle
  assign busy = (state != IDLE) | ack;

  // Bus phase straight from the state
  assign psel    = (state != IDLE);
  assign penable = (state == ACCESS);

  //////////////////////////////////////////////////////////////////////
  // Phase sequencing and completion
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= IDLE;
      ack        <= 1'b0;
      access_err <= 1'b0;
    end else begin
      ack <= 1'b0;
      case (state)
        IDLE:    if (start) state <= SETUP;
        SETUP:   state <= ACCESS;
        ACCESS: begin
          // Wait states hold the phase
          if (pready) begin
            state      <= IDLE;
            ack        <= 1'b1;
            access_err <= pslverr;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Read word taken at the end of ACCESS
  always_ff @(posedge clk) begin
    if ((state == ACCESS) && pready) begin
      raw_rdata <= prdata;
    end
  end

  // Request payload, stable for the whole transfer
  always_ff @(posedge clk) begin
    if (start) begin
      paddr       <= {adr[XLEN-1:2], 2'b00};
      pwrite      <= we;
      pwdata      <= lane_wdata;
      // No strobes on a read
      pstrb       <= we ? lane_strb : 4'b0000;
      rd_size     <= size;
      rd_ofs      <= adr[1:0];
      rd_unsigned <= load_unsigned;
    end
  end

endmodule

// ==== apb_data_ram.sv ====
// APB slave data RAM with byte strobes
// Zero wait states, error response above the RAM depth

`timescale 1ns/1ps

module apb_data_ram import lsu_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  logic [XLEN-1:0] paddr,
  input  logic            psel,
  input  logic            penable,
  input  logic            pwrite,
  input  logic [XLEN-1:0] pwdata,
  input  logic [3:0]      pstrb,
  output logic [XLEN-1:0] prdata,
  output logic            pready,
  output logic            pslverr
);

  logic [XLEN-1:0]   mem [RAM_WORDS];
  logic [RAM_AW-1:0] word_idx;
  logic              in_range;

  // Word index from the byte address
  assign word_idx = paddr[RAM_AW+1:2];

  // Any upper address bit set is past the end
  assign in_range = (paddr[XLEN-1:RAM_AW+2] == '0);

  // Never stalls
  assign pready = 1'b1;

  //////////////////////////////////////////////////////////////////////
  // Write port
  //////////////////////////////////////////////////////////////////////

  // Only strobed bytes change, nothing at all when out of range
  always_ff @(posedge clk) begin
    if (psel && penable && pwrite && in_range) begin
      for (int i = 0; i < 4; i++) begin
        if (pstrb[i]) begin
          mem[word_idx][8*i +: 8] <= pwdata[8*i +: 8];
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read data and response
  //////////////////////////////////////////////////////////////////////

  // Looked up in SETUP so both are ready for ACCESS
  always_ff @(posedge clk) begin
    if (rst) begin
      pslverr <= 1'b0;
    end else if (psel && !penable) begin
      pslverr <= ~in_range;
    end
  end

  // Out of range reads zero
  always_ff @(posedge clk) begin
    if (psel && !penable) begin
      prdata <= in_range ? mem[word_idx] : '0;
    end
  end

endmodule

// ==== lsu_top.sv ====
// Data-memory path top level
// Alignment checker, lane aligner, APB master and data RAM

`timescale 1ns/1ps

module lsu_top import lsu_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  logic            req,
  input  logic            we,
  input  logic [XLEN-1:0] adr,
  input  mem_size_t       size,
  input  logic            load_unsigned,
  input  logic [XLEN-1:0] wdata,
  output logic [XLEN-1:0] rdata,
  output logic            ack,
  output logic            access_err,
  output logic            mem_misaligned,
  output logic            busy
);

  // Checker to master
  logic            is_misaligned;

  // Aligner to master, store side
  logic [XLEN-1:0] lane_wdata;
  logic [3:0]      lane_strb;

  // Master to aligner, load side
  mem_size_t       rd_size;
  logic [1:0]      rd_ofs;
  logic            rd_unsigned;
  logic [XLEN-1:0] raw_rdata;

  // Internal APB
  logic [XLEN-1:0] paddr;
  logic            psel;
  logic            penable;
  logic            pwrite;
  logic [XLEN-1:0] pwdata;
  logic [3:0]      pstrb;
  logic [XLEN-1:0] prdata;
  logic            pready;
  logic            pslverr;

  lsu_misaligned misaligned_i (
    .clk            (clk),
    .rst            (rst),
    .req            (req),
    .adr            (adr),
    .size           (size),
    .mem_misaligned (mem_misaligned),
    .is_misaligned  (is_misaligned)
  );

  lsu_data_align align_i (
    .size        (size),
    .byte_ofs    (adr[1:0]),
    .wdata       (wdata),
    .lane_wdata  (lane_wdata),
    .lane_strb   (lane_strb),
    .rd_size     (rd_size),
    .rd_ofs      (rd_ofs),
    .rd_unsigned (rd_unsigned),
    .raw_rdata   (raw_rdata),
    .rdata       (rdata)
  );

  lsu_apb_master master_i (
    .clk           (clk),
    .rst           (rst),
    .req           (req),
    .we            (we),
    .is_misaligned (is_misaligned),
    .adr           (adr),
    .size          (size),
    .load_unsigned (load_unsigned),
    .lane_wdata    (lane_wdata),
    .lane_strb     (lane_strb),
    .busy          (busy),
    .ack           (ack),
    .access_err    (access_err),
    .rd_size       (rd_size),
    .rd_ofs        (rd_ofs),
    .rd_unsigned   (rd_unsigned),
    .raw_rdata     (raw_rdata),
    .paddr         (paddr),
    .psel          (psel),
    .penable       (penable),
    .pwrite        (pwrite),
    .pwdata        (pwdata),
    .pstrb         (pstrb),
    .prdata        (prdata),
    .pready        (pready),
    .pslverr       (pslverr)
  );

  apb_data_ram ram_i (
    .clk     (clk),
    .rst     (rst),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .pstrb   (pstrb),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

endmodule

// ==== tb_lsu_top.sv ====
// Testbench for the data-memory path top level
// Clock, reset, LFSR stimulus, byte-wise reference memory model
// Directed and random load/store tests checked by assertions

`timescale 1ns/1ps

module tb_lsu_top import lsu_pkg::*; ();

  // Cycles allowed for an ack, also the quiet window after a misaligned req
  localparam int ACK_TIMEOUT = 16;

  logic            clk;
  logic            rst;
  logic            req;
  logic            we;
  logic [XLEN-1:0] adr;
  mem_size_t       size;
  logic            load_unsigned;
  logic [XLEN-1:0] wdata;
  logic [XLEN-1:0] rdata;
  logic            ack;
  logic            access_err;
  logic            mem_misaligned;
  logic            busy;

  // Byte image of the data RAM
  logic [7:0]  model [RAM_WORDS*4];
  logic [31:0] lfsr_state = 32'hdfee;

  lsu_top dut_i (
    .clk            (clk),
    .rst            (rst),
    .req            (req),
    .we             (we),
    .adr            (adr),
    .size           (size),
    .load_unsigned  (load_unsigned),
    .wdata          (wdata),
    .rdata          (rdata),
    .ack            (ack),
    .access_err     (access_err),
    .mem_misaligned (mem_misaligned),
    .busy           (busy)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp)
      else abort_run($sformatf("[FAIL] %s: expected %h, actual %h", name, exp, act));
  endtask

  // Inputs change 1 ns after the edge, outputs are read there too
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = {lfsr_state[30:0],
                    lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // Address must be a multiple of the access width, DWORD never fits
  function automatic logic misaligned_rule(input logic [31:0] a, input mem_size_t s);
    if (s > WORD) begin
      return 1'b1;
    end
    return (a % (32'd1 << s)) != 0;
  endfunction

  function automatic logic [31:0] expected_load(input logic [31:0] a, input mem_size_t s,
                                                 input logic u);
    logic [15:0] h;
    h = {model[a+1], model[a]};
    case (s)
      BYTE:    return u ? {24'h0, model[a]} : {{24{model[a][7]}}, model[a]};
      HWORD:   return u ? {16'h0, h} : {{16{h[15]}}, h};
      default: return {model[a+3], model[a+2], model[a+1], model[a]};
    endcase
  endfunction

  task automatic model_store(input logic [31:0] a, input mem_size_t s, input logic [31:0] d);
    if (a < RAM_WORDS*4 && !misaligned_rule(a, s)) begin
      model[a] = d[7:0];
      if (s != BYTE) begin
        model[a+1] = d[15:8];
      end
      if (s == WORD) begin
        model[a+2] = d[23:16];
        model[a+3] = d[31:24];
      end
    end
  endtask

  // One request, then wait for ack or watch the quiet window
  task automatic issue(input string name, input logic w, input logic [31:0] a,
                       input mem_size_t s, input logic u, input logic [31:0] d,
                       output logic [31:0] rd, output logic err);
    int   cycles;
    logic mis_exp;
    mis_exp       = misaligned_rule(a, s);
    req           = 1'b1;
    we            = w;
    adr           = a;
    size          = s;
    load_unsigned = u;
    wdata         = d;
    next_cycle();
    req    = 1'b0;
    cycles = 1;
    rd     = '0;
    err    = 1'b0;
    check_eq({name, " mem_misaligned"}, mis_exp, mem_misaligned);
    if (mis_exp) begin
      // Nothing may reach the bus
      while (cycles < ACK_TIMEOUT) begin
        check_eq({name, " ack after misaligned"}, 0, ack);
        check_eq({name, " busy after misaligned"}, 0, busy);
        next_cycle();
        cycles++;
        check_eq({name, " mem_misaligned pulse"}, 0, mem_misaligned);
      end
    end else begin
      while (!ack) begin
        if (cycles >= ACK_TIMEOUT) begin
          abort_run($sformatf("Timeout: no ack within %0d cycles for %s at %h",
                              ACK_TIMEOUT, name, a));
        end
        check_eq({name, " busy"}, 1, busy);
        next_cycle();
        cycles++;
        check_eq({name, " mem_misaligned"}, 0, mem_misaligned);
      end
      check_eq({name, " ack latency"}, 3, cycles);
      check_eq({name, " busy at ack"}, 1, busy);
      rd  = rdata;
      err = access_err;
      // Back to idle before the next request
      next_cycle();
    end
  endtask

  // Checked on every edge outside reset
  always @(posedge clk) begin
    if (!rst) begin
      assert (!(ack && mem_misaligned))
        else abort_run("ack and mem_misaligned were high in the same cycle");
      assert (!ack || busy)
        else abort_run("ack came while busy was low");
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] r;
    logic [31:0] rd;
    logic        err;
    mem_size_t   s;
    logic [31:0] oor_adr [4];
    mem_size_t   oor_size [4];

    rst           = 1'b1;
    req           = 1'b0;
    we            = 1'b0;
    adr           = '0;
    size          = BYTE;
    load_unsigned = 1'b0;
    wdata         = '0;

    // 1. Reset state, during and right after
    for (int i = 0; i < 5; i++) begin
      next_cycle();
      check_eq("reset ack", 0, ack);
      check_eq("reset mem_misaligned", 0, mem_misaligned);
      check_eq("reset busy", 0, busy);
      check_eq("reset access_err", 0, access_err);
    end
    rst = 1'b0;
    next_cycle();
    check_eq("after reset ack", 0, ack);
    check_eq("after reset mem_misaligned", 0, mem_misaligned);
    check_eq("after reset busy", 0, busy);
    check_eq("after reset access_err", 0, access_err);

    // Known contents everywhere, pattern over the whole word index
    for (int i = 0; i < RAM_WORDS; i++) begin
      d = (i * 32'h0101_0101) ^ 32'hc3a5_5a3c;
      issue("fill", 1'b1, 32'(i * 4), WORD, 1'b0, d, rd, err);
      model_store(32'(i * 4), WORD, d);
      check_eq("fill access_err", 0, err);
    end

    // 2. Every size at every offset, loads and stores
    for (int k = 0; k < 4; k++) begin
      for (int ofs = 0; ofs < 4; ofs++) begin
        s = mem_size_t'(k);
        a = 32'h100 + ofs;
        issue("misalign load", 1'b0, a, s, 1'b0, '0, rd, err);
        if (!misaligned_rule(a, s)) begin
          check_eq("misalign load rdata", expected_load(a, s, 1'b0), rd);
        end
        d = rand_bits(32);
        issue("misalign store", 1'b1, a, s, 1'b0, d, rd, err);
        model_store(a, s, d);
      end
    end

    // 3. Random word round trips
    for (int i = 0; i < 20; i++) begin
      a = rand_bits(8);
      a = a << 2;
      d = rand_bits(32);
      issue("word store", 1'b1, a, WORD, 1'b0, d, rd, err);
      model_store(a, WORD, d);
      issue("word load", 1'b0, a, WORD, 1'b0, '0, rd, err);
      check_eq("word round trip", d, rd);
      check_eq("word access_err", 0, err);
    end

    // 4. Narrow stores merge into their word
    for (int i = 0; i < 30; i++) begin
      a = rand_bits(10);
      r = rand_bits(1);
      s = r[0] ? HWORD : BYTE;
      if (s == HWORD) begin
        a[0] = 1'b0;
      end
      d = rand_bits(32);
      issue("narrow store", 1'b1, a, s, 1'b0, d, rd, err);
      model_store(a, s, d);
      issue("merge load", 1'b0, a & 32'h3fc, WORD, 1'b0, '0, rd, err);
      check_eq("merged word", expected_load(a & 32'h3fc, WORD, 1'b0), rd);
    end

    // 5. Sign and zero extension, both signs in both widths
    issue("ext store", 1'b1, 32'h40, WORD, 1'b0, 32'h8a7f_f501, rd, err);
    model_store(32'h40, WORD, 32'h8a7f_f501);
    issue("ext store", 1'b1, 32'h44, WORD, 1'b0, 32'h7f80_01fe, rd, err);
    model_store(32'h44, WORD, 32'h7f80_01fe);
    for (int w = 0; w < 2; w++) begin
      for (int ofs = 0; ofs < 4; ofs++) begin
        for (int u = 0; u < 2; u++) begin
          a = 32'h40 + w * 4 + ofs;
          issue("byte load", 1'b0, a, BYTE, u[0], '0, rd, err);
          check_eq("byte extension", expected_load(a, BYTE, u[0]), rd);
          if (ofs % 2 == 0) begin
            issue("hword load", 1'b0, a, HWORD, u[0], '0, rd, err);
            check_eq("hword extension", expected_load(a, HWORD, u[0]), rd);
          end
        end
      end
    end

    // 6. Out of range, memory must stay as it was
    oor_adr  = '{32'h0000_0400, 32'h0000_07fc, 32'h8000_0011, 32'hffff_fffe};
    oor_size = '{WORD, WORD, BYTE, HWORD};
    for (int i = 0; i < 4; i++) begin
      d = rand_bits(32);
      issue("oor store", 1'b1, oor_adr[i], oor_size[i], 1'b0, d, rd, err);
      check_eq("oor store access_err", 1, err);
      issue("oor load", 1'b0, oor_adr[i], oor_size[i], 1'b0, '0, rd, err);
      check_eq("oor load access_err", 1, err);
      check_eq("oor load rdata", 0, rd);
      a = oor_adr[i] & 32'h3fc;
      issue("oor readback", 1'b0, a, WORD, 1'b0, '0, rd, err);
      check_eq("oor readback", expected_load(a, WORD, 1'b0), rd);
      check_eq("oor readback access_err", 0, err);
    end

    $display("Simulation PASSED");
    $finish;
  end

endmodule

// ==== lsu.f ====
lsu_pkg.sv
lsu_misaligned.sv
lsu_data_align.sv
lsu_apb_master.sv
apb_data_ram.sv
lsu_top.sv
tb_lsu_top.sv
